//--- source/cpu_pkg.sv
/* shared widths, instruction fields and encodings of the serial CPU
   opcode values not listed below execute as NOP */
`default_nettype none

package cpu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int WORD_W     = 16;
    localparam int BYTE_W     = 8;
    localparam int PC_W       = 9;
    // word address plus the byte select bit
    localparam int MEM_ADDR_W = 10;
    localparam int REG_SEL_W  = 3;
    localparam int NUM_REGS   = 8;

    // ------------------------------
    // instruction fields
    // ------------------------------
    localparam int OPC_MSB  = 15;
    localparam int OPC_LSB  = 11;
    localparam int R1_LSB   = 8;
    // bit 7 is reserved, val2 shares bits 7..4 with r2
    localparam int R2_LSB   = 4;
    localparam int R3_LSB   = 0;
    localparam int IMM8_MSB = 7;

    typedef enum logic [4:0] {
        NOP   = 5'd0,
        HALT  = 5'd1,
        LOAD  = 5'd2,
        STORE = 5'd3,
        LDIH  = 5'd4,
        ADD   = 5'd5,
        ADDI  = 5'd6,
        SUB   = 5'd8,
        SUBI  = 5'd9,
        CMP   = 5'd12,
        AND   = 5'd13,
        OR    = 5'd14,
        XOR   = 5'd15,
        SLL   = 5'd16,
        SRL   = 5'd17,
        SET   = 5'd18,
        JUMP  = 5'd24,
        JMPR  = 5'd25,
        BZ    = 5'd26,
        BNZ   = 5'd27,
        BN    = 5'd28,
        BNN   = 5'd29,
        BC    = 5'd30,
        BNC   = 5'd31
    } opcode_e;

    // one instruction walks IF through WB in eight cycles
    typedef enum logic [3:0] {
        IDLE = 4'd0,
        IF   = 4'd1,
        IF2  = 4'd2,
        ID   = 4'd3,
        EX   = 4'd4,
        EX2  = 4'd5,
        MEM  = 4'd6,
        MEM2 = 4'd7,
        WB   = 4'd8
    } cpu_state_e;

    typedef enum logic [1:0] {
        NONE           = 2'd0,
        HALTED         = 2'd1,
        END_OF_PROGRAM = 2'd2
    } stop_cause_e;

endpackage

`default_nettype wire

//--- source/cpu_sequencer.sv
/* fetches each instruction as two bytes, high byte first
   a run ends on HALT or after the instruction at the last program word */
`default_nettype none

module cpu_sequencer (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                i_start,
    input  wire  [cpu_pkg::BYTE_W-1:0]         i_instr_byte,
    input  wire                                i_branch_taken,
    input  wire  [cpu_pkg::PC_W-1:0]           i_branch_target,
    output cpu_pkg::cpu_state_e                o_state,
    output logic [cpu_pkg::WORD_W-1:0]         o_instr,
    output logic [cpu_pkg::MEM_ADDR_W-1:0]     o_instr_addr,
    output logic                               o_busy,
    output cpu_pkg::stop_cause_e               o_stop_cause
);

    cpu_pkg::cpu_state_e         state;
    cpu_pkg::cpu_state_e         next_state;
    cpu_pkg::opcode_e            opcode;
    logic [cpu_pkg::PC_W-1:0]    pc;
    logic [cpu_pkg::WORD_W-1:0]  ir;
    logic                        last_word;
    logic                        run_done;

    assign opcode    = cpu_pkg::opcode_e'(ir[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB]);
    assign last_word = &pc;
    assign run_done  = (opcode == cpu_pkg::HALT) || last_word;

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= cpu_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            cpu_pkg::IDLE:
            begin
                if (i_start)
                    next_state = cpu_pkg::IF;
            end
            cpu_pkg::IF:   next_state = cpu_pkg::IF2;
            cpu_pkg::IF2:  next_state = cpu_pkg::ID;
            cpu_pkg::ID:   next_state = cpu_pkg::EX;
            cpu_pkg::EX:   next_state = cpu_pkg::EX2;
            cpu_pkg::EX2:  next_state = cpu_pkg::MEM;
            cpu_pkg::MEM:  next_state = cpu_pkg::MEM2;
            cpu_pkg::MEM2: next_state = cpu_pkg::WB;
            cpu_pkg::WB:
            begin
                if (run_done)
                    next_state = cpu_pkg::IDLE;
                else
                    next_state = cpu_pkg::IF;
            end
            default:       next_state = cpu_pkg::IDLE;
        endcase
    end

    // ------------------------------
    // program counter and stop cause
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc           <= '0;
            o_stop_cause <= cpu_pkg::NONE;
        end
        else if (state == cpu_pkg::IDLE)
        begin
            if (i_start)
            begin
                pc           <= '0;
                o_stop_cause <= cpu_pkg::NONE;
            end
        end
        else if (state == cpu_pkg::WB)
        begin
            // pc sticks at the last word so the stop check sees it
            if (i_branch_taken)
                pc <= i_branch_target;
            else if (!last_word)
                pc <= pc + 1'b1;

            if (opcode == cpu_pkg::HALT)
                o_stop_cause <= cpu_pkg::HALTED;
            else if (last_word)
                o_stop_cause <= cpu_pkg::END_OF_PROGRAM;
        end
    end

    // instruction register, high byte in IF and low byte in IF2
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= {cpu_pkg::NOP, {cpu_pkg::OPC_LSB{1'b0}}};
        else if (state == cpu_pkg::IF)
            ir[cpu_pkg::WORD_W-1:cpu_pkg::BYTE_W] <= i_instr_byte;
        else if (state == cpu_pkg::IF2)
            ir[cpu_pkg::BYTE_W-1:0] <= i_instr_byte;
    end

    // odd byte address only during IF2
    assign o_instr_addr = {pc, state == cpu_pkg::IF2};
    assign o_state      = state;
    assign o_instr      = ir;
    assign o_busy       = (state != cpu_pkg::IDLE);

endmodule

`default_nettype wire

//--- source/reg_file.sv
/* eight general registers with combinational reads
   each byte lane has its own write enable so LOAD can fill a word in halves */
`default_nettype none

module reg_file (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [cpu_pkg::REG_SEL_W-1:0]     i_rd_sel_a,
    input  wire  [cpu_pkg::REG_SEL_W-1:0]     i_rd_sel_b,
    input  wire  [cpu_pkg::REG_SEL_W-1:0]     i_wr_sel,
    input  wire                               i_we_lo,
    input  wire                               i_we_hi,
    input  wire  [cpu_pkg::WORD_W-1:0]        i_wr_data,
    output logic [cpu_pkg::WORD_W-1:0]        o_rd_data_a,
    output logic [cpu_pkg::WORD_W-1:0]        o_rd_data_b
);

    logic [cpu_pkg::WORD_W-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (i_we_lo)
                regs[i_wr_sel][cpu_pkg::BYTE_W-1:0] <= i_wr_data[cpu_pkg::BYTE_W-1:0];
            if (i_we_hi)
                regs[i_wr_sel][cpu_pkg::WORD_W-1:cpu_pkg::BYTE_W] <=
                    i_wr_data[cpu_pkg::WORD_W-1:cpu_pkg::BYTE_W];
        end
    end

    // a read in the write cycle sees the old value
    assign o_rd_data_a = regs[i_rd_sel_a];
    assign o_rd_data_b = regs[i_rd_sel_b];

endmodule

`default_nettype wire

//--- source/exec_unit.sv
/* operands latch in EX, result and flags in EX2; memory bytes move in MEM and MEM2
   data words are little endian, low byte at the even address */
`default_nettype none

module exec_unit (
    input  wire                               clk,
    input  wire                               rst_n,
    input  cpu_pkg::cpu_state_e               i_state,
    input  wire  [cpu_pkg::WORD_W-1:0]        i_instr,
    input  wire  [cpu_pkg::WORD_W-1:0]        i_rd_data_a,
    input  wire  [cpu_pkg::WORD_W-1:0]        i_rd_data_b,
    input  wire  [cpu_pkg::BYTE_W-1:0]        i_data_byte,
    output logic [cpu_pkg::REG_SEL_W-1:0]     o_rd_sel_a,
    output logic [cpu_pkg::REG_SEL_W-1:0]     o_rd_sel_b,
    output logic [cpu_pkg::REG_SEL_W-1:0]     o_wr_sel,
    output logic                              o_we_lo,
    output logic                              o_we_hi,
    output logic [cpu_pkg::WORD_W-1:0]        o_wr_data,
    output logic [cpu_pkg::MEM_ADDR_W-1:0]    o_data_addr,
    output logic [cpu_pkg::BYTE_W-1:0]        o_data_byte,
    output logic                              o_d_we,
    output logic                              o_branch_taken,
    output logic [cpu_pkg::PC_W-1:0]          o_branch_target
);

    cpu_pkg::opcode_e                 opcode;
    logic [cpu_pkg::REG_SEL_W-1:0]    r1;
    logic [cpu_pkg::REG_SEL_W-1:0]    r2;
    logic [cpu_pkg::REG_SEL_W-1:0]    r3;
    logic [cpu_pkg::WORD_W-1:0]       imm8_ext;
    logic [cpu_pkg::WORD_W-1:0]       val3_ext;
    logic [cpu_pkg::WORD_W-1:0]       a_next;
    logic [cpu_pkg::WORD_W-1:0]       b_next;
    logic [cpu_pkg::WORD_W-1:0]       op_a;
    logic [cpu_pkg::WORD_W-1:0]       op_b;
    logic [cpu_pkg::WORD_W-1:0]       store_data;
    logic [cpu_pkg::WORD_W-1:0]       alu_res;
    logic                             alu_carry;
    logic [cpu_pkg::WORD_W-1:0]       result;
    logic                             zf;
    logic                             nf;
    logic                             cf;
    logic                             sets_flags;
    logic                             writes_reg;
    logic                             is_load;
    logic                             in_mem;

    assign opcode   = cpu_pkg::opcode_e'(i_instr[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB]);
    assign r1       = i_instr[cpu_pkg::R1_LSB +: cpu_pkg::REG_SEL_W];
    assign r2       = i_instr[cpu_pkg::R2_LSB +: cpu_pkg::REG_SEL_W];
    assign r3       = i_instr[cpu_pkg::R3_LSB +: cpu_pkg::REG_SEL_W];
    assign imm8_ext = {{cpu_pkg::BYTE_W{1'b0}}, i_instr[cpu_pkg::IMM8_MSB:0]};
    assign val3_ext = {{(cpu_pkg::WORD_W - cpu_pkg::R2_LSB){1'b0}},
                       i_instr[cpu_pkg::R2_LSB-1:cpu_pkg::R3_LSB]};

    // ------------------------------
    // operand selection
    // ------------------------------
    always_comb
    begin
        o_rd_sel_a = r2;
        // port b doubles as the store data read
        o_rd_sel_b = (opcode == cpu_pkg::STORE) ? r1 : r3;
        a_next     = i_rd_data_a;
        b_next     = i_rd_data_b;
        case (opcode)
            cpu_pkg::JUMP:
            begin
                a_next = '0;
                b_next = imm8_ext;
            end
            cpu_pkg::LOAD, cpu_pkg::STORE, cpu_pkg::SLL, cpu_pkg::SRL:
                b_next = val3_ext;
            cpu_pkg::LDIH:
            begin
                o_rd_sel_a = r1;
                b_next     = {i_instr[cpu_pkg::IMM8_MSB:0], {cpu_pkg::BYTE_W{1'b0}}};
            end
            cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::SET, cpu_pkg::JMPR,
            cpu_pkg::BZ, cpu_pkg::BNZ, cpu_pkg::BN, cpu_pkg::BNN,
            cpu_pkg::BC, cpu_pkg::BNC:
            begin
                o_rd_sel_a = r1;
                b_next     = imm8_ext;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_state == cpu_pkg::EX)
        begin
            op_a <= a_next;
            op_b <= b_next;
            if (opcode == cpu_pkg::STORE)
                store_data <= i_rd_data_b;
        end
    end

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb
    begin
        {alu_carry, alu_res} = {1'b0, op_a} + {1'b0, op_b};
        case (opcode)
            cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP:
                {alu_carry, alu_res} = {1'b0, op_a} - {1'b0, op_b};
            cpu_pkg::AND: {alu_carry, alu_res} = {1'b0, op_a & op_b};
            cpu_pkg::OR:  {alu_carry, alu_res} = {1'b0, op_a | op_b};
            cpu_pkg::XOR: {alu_carry, alu_res} = {1'b0, op_a ^ op_b};
            // shifts keep the old carry
            cpu_pkg::SLL:
                {alu_carry, alu_res} = {cf, op_a << op_b[$clog2(cpu_pkg::WORD_W)-1:0]};
            cpu_pkg::SRL:
                {alu_carry, alu_res} = {cf, op_a >> op_b[$clog2(cpu_pkg::WORD_W)-1:0]};
            cpu_pkg::SET, cpu_pkg::JUMP:
                {alu_carry, alu_res} = {cf, op_b};
            default: ;
        endcase
    end

    always_comb
    begin
        case (opcode)
            cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP,
            cpu_pkg::LDIH, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR,
            cpu_pkg::SLL, cpu_pkg::SRL:
                sets_flags = 1'b1;
            default:
                sets_flags = 1'b0;
        endcase
        case (opcode)
            cpu_pkg::LDIH, cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::SUB, cpu_pkg::SUBI,
            cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRL,
            cpu_pkg::SET:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result <= '0;
            zf     <= 1'b0;
            nf     <= 1'b0;
            cf     <= 1'b0;
        end
        else if (i_state == cpu_pkg::EX2)
        begin
            result <= alu_res;
            if (sets_flags)
            begin
                zf <= (alu_res == '0);
                nf <= alu_res[cpu_pkg::WORD_W-1];
                cf <= alu_carry;
            end
        end
    end

    // ------------------------------
    // memory access and writeback
    // ------------------------------
    assign is_load = (opcode == cpu_pkg::LOAD);
    assign in_mem  = (i_state == cpu_pkg::MEM) || (i_state == cpu_pkg::MEM2);

    // byte bit is set only in MEM2
    assign o_data_addr = {result[cpu_pkg::PC_W-1:0], i_state == cpu_pkg::MEM2};
    assign o_data_byte = (i_state == cpu_pkg::MEM2) ?
                         store_data[cpu_pkg::WORD_W-1:cpu_pkg::BYTE_W] :
                         store_data[cpu_pkg::BYTE_W-1:0];
    assign o_d_we      = in_mem && (opcode == cpu_pkg::STORE);

    assign o_wr_sel  = r1;
    assign o_we_lo   = (is_load && i_state == cpu_pkg::MEM) ||
                       (writes_reg && i_state == cpu_pkg::WB);
    assign o_we_hi   = (is_load && i_state == cpu_pkg::MEM2) ||
                       (writes_reg && i_state == cpu_pkg::WB);
    // the load byte is copied to both lanes, the enables pick one
    assign o_wr_data = is_load ? {i_data_byte, i_data_byte} : result;

    // ------------------------------
    // branch decision
    // ------------------------------
    always_comb
    begin
        case (opcode)
            cpu_pkg::JUMP, cpu_pkg::JMPR: o_branch_taken = 1'b1;
            cpu_pkg::BZ:                  o_branch_taken = zf;
            cpu_pkg::BNZ:                 o_branch_taken = !zf;
            cpu_pkg::BN:                  o_branch_taken = nf;
            cpu_pkg::BNN:                 o_branch_taken = !nf;
            cpu_pkg::BC:                  o_branch_taken = cf;
            cpu_pkg::BNC:                 o_branch_taken = !cf;
            default:                      o_branch_taken = 1'b0;
        endcase
    end

    assign o_branch_target = result[cpu_pkg::PC_W-1:0];

endmodule

`default_nettype wire

//--- source/serial_cpu_top.sv
/* serial 16-bit CPU core on an 8-bit bus
   instruction and data memories sit outside and answer combinationally */
`default_nettype none

module serial_cpu_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_start,
    input  wire  [cpu_pkg::BYTE_W-1:0]        i_instr_byte,
    input  wire  [cpu_pkg::BYTE_W-1:0]        i_data_byte,
    output logic [cpu_pkg::MEM_ADDR_W-1:0]    o_instr_addr,
    output logic [cpu_pkg::MEM_ADDR_W-1:0]    o_data_addr,
    output logic [cpu_pkg::BYTE_W-1:0]        o_data_byte,
    output logic                              o_d_we,
    output logic                              o_busy,
    output cpu_pkg::stop_cause_e              o_stop_cause
);

    cpu_pkg::cpu_state_e              state;
    logic [cpu_pkg::WORD_W-1:0]       instr;
    logic                             branch_taken;
    logic [cpu_pkg::PC_W-1:0]         branch_target;
    logic [cpu_pkg::REG_SEL_W-1:0]    rd_sel_a;
    logic [cpu_pkg::REG_SEL_W-1:0]    rd_sel_b;
    logic [cpu_pkg::REG_SEL_W-1:0]    wr_sel;
    logic                             we_lo;
    logic                             we_hi;
    logic [cpu_pkg::WORD_W-1:0]       wr_data;
    logic [cpu_pkg::WORD_W-1:0]       rd_data_a;
    logic [cpu_pkg::WORD_W-1:0]       rd_data_b;

    cpu_sequencer cpu_sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_instr_byte    (i_instr_byte),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_state         (state),
        .o_instr         (instr),
        .o_instr_addr    (o_instr_addr),
        .o_busy          (o_busy),
        .o_stop_cause    (o_stop_cause)
    );

    reg_file reg_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_rd_sel_a  (rd_sel_a),
        .i_rd_sel_b  (rd_sel_b),
        .i_wr_sel    (wr_sel),
        .i_we_lo     (we_lo),
        .i_we_hi     (we_hi),
        .i_wr_data   (wr_data),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    exec_unit exec_unit_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_state         (state),
        .i_instr         (instr),
        .i_rd_data_a     (rd_data_a),
        .i_rd_data_b     (rd_data_b),
        .i_data_byte     (i_data_byte),
        .o_rd_sel_a      (rd_sel_a),
        .o_rd_sel_b      (rd_sel_b),
        .o_wr_sel        (wr_sel),
        .o_we_lo         (we_lo),
        .o_we_hi         (we_hi),
        .o_wr_data       (wr_data),
        .o_data_addr     (o_data_addr),
        .o_data_byte     (o_data_byte),
        .o_d_we          (o_d_we),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

endmodule

`default_nettype wire

//--- verification/cpu_checker.sv
/* pairs each two-cycle store into a word and compares it with the expected list
   expected stores are queued by the testbench, stop causes come in per run */
`default_nettype none

module cpu_checker (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_d_we,
    input  wire  [cpu_pkg::MEM_ADDR_W-1:0]    i_data_addr,
    input  wire  [cpu_pkg::BYTE_W-1:0]        i_data_byte,
    input  wire                               i_busy,
    input  wire  [1:0]                        i_stop_cause
);

    int                          errors = 0;
    int                          tests  = 0;
    int                          exp_addr [$];
    logic [cpu_pkg::WORD_W-1:0]  exp_val [$];
    logic [cpu_pkg::BYTE_W-1:0]  lo_byte;

    task automatic add_store(input int waddr, input logic [cpu_pkg::WORD_W-1:0] val);
        exp_addr.push_back(waddr);
        exp_val.push_back(val);
    endtask

    task automatic check_store(input int waddr, input logic [cpu_pkg::WORD_W-1:0] val);
        int                          want_addr;
        logic [cpu_pkg::WORD_W-1:0]  want_val;
        tests++;
        if (exp_addr.size() == 0)
        begin
            errors++;
            $display("store test %0d: unexpected store of %h to word %0d", tests, val, waddr);
        end
        else
        begin
            want_addr = exp_addr.pop_front();
            want_val  = exp_val.pop_front();
            if (want_addr != waddr || want_val != val)
            begin
                errors++;
                if (want_addr != waddr)
                    $display("MISMATCH o_data_addr word expected %h got %h", want_addr, waddr);
                if (want_val != val)
                    $display("MISMATCH o_data_byte word expected %h got %h", want_val, val);
                $display("store test %0d: fail", tests);
            end
            else
                $display("store test %0d: pass, word %0d = %h", tests, waddr, val);
        end
    endtask

    // low byte comes first at the even address
    always @(posedge clk)
    begin
        if (rst_n && i_d_we)
        begin
            if (!i_data_addr[0])
                lo_byte <= i_data_byte;
            else
                check_store(int'(i_data_addr[cpu_pkg::MEM_ADDR_W-1:1]), {i_data_byte, lo_byte});
        end
    end

    task automatic check_run(input int run_idx, input logic [1:0] want_cause);
        logic ok;
        ok = 1'b1;
        tests++;
        if (i_stop_cause != want_cause)
        begin
            ok = 1'b0;
            $display("MISMATCH o_stop_cause expected %h got %h", want_cause, i_stop_cause);
        end
        if (i_busy)
        begin
            ok = 1'b0;
            $display("o_busy is still high after run %0d", run_idx);
        end
        if (!ok)
            errors++;
        $display("run test %0d (run %0d): %s", tests, run_idx, ok ? "pass" : "fail");
    endtask

    task automatic report();
        if (exp_addr.size() != 0)
        begin
            errors++;
            $display("%0d expected stores never happened", exp_addr.size());
        end
        $display("tests run: %0d, errors: %0d", tests, errors);
    endtask

endmodule

`default_nettype wire

//--- verification/cpu_assertions.sv
/* bus rules of the core, bound to the top level */
`default_nettype none

module cpu_assertions (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_d_we,
    input  wire  [cpu_pkg::MEM_ADDR_W-1:0]    i_data_addr,
    input  wire                               i_busy,
    input  wire  [1:0]                        i_stop_cause
);

    no_write_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_d_we |-> i_busy)
        else $error("data write while the core is idle");

    // even byte, then odd byte, then the enable drops
    two_byte_store: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_d_we) |-> !i_data_addr[0] ##1 (i_d_we && i_data_addr[0]) ##1 !i_d_we)
        else $error("store is not an even then odd two-cycle write");

    no_cause_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_busy |-> (i_stop_cause == 2'd0))
        else $error("stop cause set while the core is busy");

endmodule

bind serial_cpu_top cpu_assertions cpu_assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_d_we       (o_d_we),
    .i_data_addr  (o_data_addr),
    .i_busy       (o_busy),
    .i_stop_cause (o_stop_cause)
);

`default_nettype wire

//--- verification/tb_top.sv
/* loads program, data and expected results from the input file, then runs the core once
   per expected stop cause; both memories answer combinationally */
`default_nettype none

module tb_top;

    localparam int MEM_BYTES   = 1 << cpu_pkg::MEM_ADDR_W;
    localparam int RUN_TIMEOUT = 4000;

    logic                             clk;
    logic                             rst_n;
    logic                             i_start;
    wire  [cpu_pkg::BYTE_W-1:0]       instr_byte;
    wire  [cpu_pkg::BYTE_W-1:0]       data_byte_in;
    wire  [cpu_pkg::MEM_ADDR_W-1:0]   instr_addr;
    wire  [cpu_pkg::MEM_ADDR_W-1:0]   data_addr;
    wire  [cpu_pkg::BYTE_W-1:0]       data_byte_out;
    wire                              d_we;
    wire                              busy;
    cpu_pkg::stop_cause_e             stop_cause;

    logic [cpu_pkg::BYTE_W-1:0]       instr_mem [MEM_BYTES];
    logic [cpu_pkg::BYTE_W-1:0]       data_mem [MEM_BYTES];
    int                               exp_causes [$];
    logic                             file_ok;
    logic                             timed_out;

    serial_cpu_top serial_cpu_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .i_instr_byte (instr_byte),
        .i_data_byte  (data_byte_in),
        .o_instr_addr (instr_addr),
        .o_data_addr  (data_addr),
        .o_data_byte  (data_byte_out),
        .o_d_we       (d_we),
        .o_busy       (busy),
        .o_stop_cause (stop_cause)
    );

    cpu_checker checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_d_we       (d_we),
        .i_data_addr  (data_addr),
        .i_data_byte  (data_byte_out),
        .i_busy       (busy),
        .i_stop_cause (stop_cause)
    );

    always #20 clk = ~clk;

    // ------------------------------
    // memory models
    // ------------------------------
    assign instr_byte   = instr_mem[instr_addr];
    assign data_byte_in = data_mem[data_addr];

    always @(posedge clk)
    begin
        if (d_we)
            data_mem[data_addr] <= data_byte_out;
    end

    task automatic load_input_file(output logic ok);
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] a;
        logic [31:0] b;
        ok = 1'b1;
        fd = $fopen("verification/program_input.txt", "r");
        if (fd == 0)
        begin
            ok = 1'b0;
            $display("cannot open the program input file");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%c %h %h", kind, a, b);
                    case (kind)
                        "P":
                        begin
                            instr_mem[2 * a]     = b[15:8];
                            instr_mem[2 * a + 1] = b[7:0];
                        end
                        "D": data_mem[a] = b[7:0];
                        "S": checker_i.add_store(int'(a), b[15:0]);
                        "C": exp_causes.push_back(int'(a));
                        default: $display("ignored input line: %s", line);
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // start pulse, then wait for o_busy to fall
    task automatic run_program(input int run_idx, output logic expired);
        int cycles;
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        @(negedge clk);
        cycles = 0;
        while (busy && cycles < RUN_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        expired = busy;
        if (busy)
            $display("timeout: run %0d did not finish within %0d cycles",
                     run_idx, RUN_TIMEOUT);
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        i_start   = 1'b0;
        timed_out = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            instr_mem[i] = '0;
            data_mem[i]  = '0;
        end
        load_input_file(file_ok);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < exp_causes.size() && !timed_out; r++)
        begin
            run_program(r + 1, timed_out);
            if (!timed_out)
            begin
                // core must stay idle without a new start
                @(negedge clk);
                checker_i.check_run(r + 1, exp_causes[r][1:0]);
            end
        end
        checker_i.report();
        if (!file_ok || timed_out || checker_i.errors != 0)
            $display("CHECKS FAILED");
        else
            $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/cpu_pkg.sv
source/cpu_sequencer.sv
source/reg_file.sv
source/exec_unit.sv
source/serial_cpu_top.sv
verification/cpu_checker.sv
verification/cpu_assertions.sv
verification/tb_top.sv

//--- run.sh
#!/bin/sh
# builds the simulation with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation finished without failures"
exit 0

//--- verification/program_input.txt
# P word instr : program word (hex), D byte_addr byte : initial data byte
# S word value : expected store in order, C cause : expected stop cause per run
P 000 1100
P 001 3100
P 002 D832
P 003 9234
P 004 2212
P 005 1A01
P 006 9305
P 007 2C23
P 008 1C02
P 009 3410
P 00A 1C03
P 00B 4423
P 00C 1C04
P 00D 4C2F
P 00E 1C05
P 00F 6C23
P 010 1C06
P 011 7423
P 012 1C07
P 013 7C23
P 014 1C08
P 015 8424
P 016 1C09
P 017 8C23
P 018 1C0A
P 019 150F
P 01A 3500
P 01B 1D0B
P 01C 6022
P 01D D81F
P 01E D020
P 01F 1A0C
P 020 4632
P 021 F023
P 022 1A0C
P 023 E025
P 024 1A0C
P 025 1E0C
P 026 C02A
P 027 1A0D
P 028 1A0D
P 029 1A0D
P 02A 9701
P 02B 1F00
P 02C 0800
P 032 95FF
P 033 2501
P 034 CD00
P 1FF 0000
D 01E EF
D 01F BE
S 001 1234
S 002 1239
S 003 1249
S 004 122F
S 005 1200
S 006 0004
S 007 1235
S 008 1231
S 009 2340
S 00A 0246
S 00B BEEF
S 00C EDD1
S 000 0001
C 1
C 2
